//--- logic/rv32i_types.sv
package rv32i_types;

    // Data and address words.
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef xlen_t       pc_t;

    // Instruction fields.
    typedef logic [4:0] reg_idx_t;
    typedef logic [6:0] opcode_t;

    // Operation class handed to dispatch.
    typedef logic [2:0] op_class_t;

    localparam op_class_t OP_ALU     = 3'd0; // OP, OP-IMM, LUI, AUIPC.
    localparam op_class_t OP_LOAD    = 3'd1;
    localparam op_class_t OP_STORE   = 3'd2;
    localparam op_class_t OP_BRANCH  = 3'd3;
    localparam op_class_t OP_JUMP    = 3'd4; // JAL and JALR.
    localparam op_class_t OP_ILLEGAL = 3'd5;

    // RV32I base opcodes.
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // One fetched slot as held in the instruction queue.
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t instr;
    } queue_entry_t;

    // Defaults for the top-level parameters.
    localparam int DEFAULT_SS        = 2;
    localparam int DEFAULT_DEPTH     = 8;
    localparam int DEFAULT_ROB_DEPTH = 16;

endpackage : rv32i_types

//--- logic/lane_if.sv
`timescale 1ns/1ps

// One decoded slot on its way from a lane to the merger.
interface lane_if;
    import rv32i_types::*;

    logic      valid;
    xlen_t     pc;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    xlen_t     imm;
    op_class_t op_class;

    modport lane_mp (
        output valid, pc, rd, rs1, rs2, imm, op_class
    );

    modport merge_mp (
        input valid, pc, rd, rs1, rs2, imm, op_class
    );

endinterface : lane_if

//--- logic/circular_queue.sv
`timescale 1ns/1ps

module circular_queue #(
    parameter type QUEUE_TYPE = rv32i_types::queue_entry_t,
    parameter int  SS         = rv32i_types::DEFAULT_SS,
    parameter int  DEPTH      = rv32i_types::DEFAULT_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic                     pop,
    input  QUEUE_TYPE                in_group [SS],
    input  logic                     peek_en,
    input  logic [$clog2(DEPTH)-1:0] peek_index,
    output logic                     empty,
    output logic                     full,
    output logic [$clog2(DEPTH):0]   count,
    output QUEUE_TYPE                out_group [SS],
    output logic                     out_strobe,
    output QUEUE_TYPE                peek_data
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] STEP = (AW + 1)'(SS); // Pointers move a whole group.

    QUEUE_TYPE entries [DEPTH];

    // Extra top bit tells a full queue from an empty one.
    logic [AW:0]   head;
    logic [AW:0]   tail;
    logic [AW-1:0] head_idx;
    logic [AW-1:0] tail_idx;
    logic          do_push;
    logic          do_pop;

    assign head_idx = head[AW-1:0];
    assign tail_idx = tail[AW-1:0];

    assign empty = (head == tail);
    assign full  = (head_idx == tail_idx) && (head[AW] != tail[AW]);
    assign count = head - tail; // Wraps cleanly since DEPTH is a power of two.

    assign do_push = push && !full; // Push into a full queue is dropped.
    assign do_pop  = pop && !empty;

    // Pointers and output strobe.
    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            out_strobe <= 1'b0;
        end else begin
            if (do_push) begin
                head <= head + STEP;
            end
            if (do_pop) begin
                tail <= tail + STEP;
            end
            out_strobe <= do_pop;
        end
    end

    // Entry storage and registered read ports.
    always_ff @(posedge clk) begin
        if (do_push) begin
            for (int i = 0; i < SS; i++) begin
                entries[head_idx + AW'(i)] <= in_group[i];
            end
        end

        // Groups are SS aligned, so a group never wraps.
        if (do_pop) begin
            for (int i = 0; i < SS; i++) begin
                out_group[i] <= entries[tail_idx + AW'(i)];
            end
        end

        if (peek_en) begin
            peek_data <= entries[peek_index]; // Holds while peek_en is low.
        end
    end

    // Occupancy stays within the storage.
    a_count_bound : assert property (
        @(posedge clk) disable iff (rst)
        count <= (AW + 1)'(DEPTH)
    );

    // No group leaves the queue on the first cycle out of reset.
    a_no_strobe_after_reset : assert property (
        @(posedge clk)
        $fell(rst) |=> !out_strobe
    );

endmodule : circular_queue

//--- logic/decode_lane.sv
`timescale 1ns/1ps

module decode_lane (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     slot_strobe,
    input  rv32i_types::queue_entry_t slot,
    lane_if.lane_mp                  dec
);

    import rv32i_types::*;

    instr_t    ins;
    opcode_t   opcode;
    xlen_t     imm_i;
    xlen_t     imm_s;
    xlen_t     imm_b;
    xlen_t     imm_u;
    xlen_t     imm_j;
    xlen_t     imm_d;
    op_class_t class_d;

    assign ins    = slot.instr;
    assign opcode = ins[6:0];

    // Immediate formats, all sign-extended from bit 31.
    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    // Opcode picks the class and the immediate format.
    always_comb begin
        imm_d   = '0;
        class_d = OP_ILLEGAL;
        case (opcode)
            OPC_OP: begin
                class_d = OP_ALU; // Register-register, no immediate.
            end
            OPC_OP_IMM: begin
                class_d = OP_ALU;
                imm_d   = imm_i;
            end
            OPC_LUI, OPC_AUIPC: begin
                class_d = OP_ALU;
                imm_d   = imm_u;
            end
            OPC_LOAD: begin
                class_d = OP_LOAD;
                imm_d   = imm_i;
            end
            OPC_STORE: begin
                class_d = OP_STORE;
                imm_d   = imm_s;
            end
            OPC_BRANCH: begin
                class_d = OP_BRANCH;
                imm_d   = imm_b;
            end
            OPC_JAL: begin
                class_d = OP_JUMP;
                imm_d   = imm_j;
            end
            OPC_JALR: begin
                class_d = OP_JUMP;
                imm_d   = imm_i;
            end
            default: begin
                class_d = OP_ILLEGAL;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= slot_strobe && slot.valid;
        end
    end

    // Decoded fields, only loaded with a new group.
    always_ff @(posedge clk) begin
        if (slot_strobe) begin
            dec.pc       <= slot.pc;
            dec.rd       <= ins[11:7];
            dec.rs1      <= ins[19:15];
            dec.rs2      <= ins[24:20];
            dec.imm      <= imm_d;
            dec.op_class <= class_d;
        end
    end

    // A valid jump carries a known link register and target offset.
    a_jump_fields_known : assert property (
        @(posedge clk) disable iff (rst)
        (dec.valid && dec.op_class == OP_JUMP) |-> !$isunknown({dec.rd, dec.imm})
    );

endmodule : decode_lane

//--- logic/dispatch_merge.sv
`timescale 1ns/1ps

module dispatch_merge #(
    parameter int SS        = rv32i_types::DEFAULT_SS,
    parameter int ROB_DEPTH = rv32i_types::DEFAULT_ROB_DEPTH
) (
    input  logic                           clk,
    input  logic                           rst,
    lane_if.merge_mp                       lanes [SS],
    output logic                           dispatch_valid [SS],
    output logic [$clog2(ROB_DEPTH)-1:0]   dispatch_tag   [SS],
    output rv32i_types::xlen_t             dispatch_pc    [SS],
    output rv32i_types::reg_idx_t          dispatch_rd    [SS],
    output rv32i_types::reg_idx_t          dispatch_rs1   [SS],
    output rv32i_types::reg_idx_t          dispatch_rs2   [SS],
    output rv32i_types::xlen_t             dispatch_imm   [SS],
    output rv32i_types::op_class_t         dispatch_class [SS]
);

    import rv32i_types::*;

    localparam int TW = $clog2(ROB_DEPTH);

    logic      lane_valid [SS];
    xlen_t     lane_pc    [SS];
    reg_idx_t  lane_rd    [SS];
    reg_idx_t  lane_rs1   [SS];
    reg_idx_t  lane_rs2   [SS];
    xlen_t     lane_imm   [SS];
    op_class_t lane_class [SS];

    logic [TW-1:0] lane_tag [SS];
    logic [TW-1:0] tag_count; // Tag for the first valid slot this cycle.
    logic [TW-1:0] tag_next;

    for (genvar g = 0; g < SS; g++) begin : g_unpack
        assign lane_valid[g] = lanes[g].valid;
        assign lane_pc[g]    = lanes[g].pc;
        assign lane_rd[g]    = lanes[g].rd;
        assign lane_rs1[g]   = lanes[g].rs1;
        assign lane_rs2[g]   = lanes[g].rs2;
        assign lane_imm[g]   = lanes[g].imm;
        assign lane_class[g] = lanes[g].op_class;
    end

    // Valid lanes take consecutive tags in lane order.
    always_comb begin
        logic [TW-1:0] offset;
        offset = '0;
        for (int i = 0; i < SS; i++) begin
            lane_tag[i] = tag_count + offset;
            offset      = offset + TW'(lane_valid[i]);
        end
        tag_next = tag_count + offset; // Wraps modulo ROB_DEPTH.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_count <= '0;
            for (int i = 0; i < SS; i++) begin
                dispatch_valid[i] <= 1'b0;
            end
        end else begin
            tag_count <= tag_next;
            for (int i = 0; i < SS; i++) begin
                dispatch_valid[i] <= lane_valid[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SS; i++) begin
            dispatch_tag[i]   <= lane_tag[i];
            dispatch_pc[i]    <= lane_pc[i];
            dispatch_rd[i]    <= lane_rd[i];
            dispatch_rs1[i]   <= lane_rs1[i];
            dispatch_rs2[i]   <= lane_rs2[i];
            dispatch_imm[i]   <= lane_imm[i];
            dispatch_class[i] <= lane_class[i];
        end
    end

    // No two slots leave in the same cycle with one tag.
    for (genvar a = 0; a < SS; a++) begin : g_tag_a
        for (genvar b = a + 1; b < SS; b++) begin : g_tag_b
            a_tags_distinct : assert property (
                @(posedge clk) disable iff (rst)
                (dispatch_valid[a] && dispatch_valid[b]) |-> dispatch_tag[a] != dispatch_tag[b]
            );
        end
    end

endmodule : dispatch_merge

//--- logic/decode_stage_top.sv
`timescale 1ns/1ps

module decode_stage_top #(
    parameter int SS        = rv32i_types::DEFAULT_SS,
    parameter int DEPTH     = rv32i_types::DEFAULT_DEPTH,
    parameter int ROB_DEPTH = rv32i_types::DEFAULT_ROB_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  logic                         stall,
    input  logic                         peek_en,
    input  logic                         fetch_valid [SS],
    input  rv32i_types::xlen_t           fetch_pc    [SS],
    input  rv32i_types::instr_t          fetch_instr [SS],
    input  logic [$clog2(DEPTH)-1:0]     peek_index,
    output logic                         empty,
    output logic                         full,
    output logic                         peek_valid_bit,
    output rv32i_types::xlen_t           peek_pc,
    output rv32i_types::instr_t          peek_instr,
    output logic                         dispatch_valid [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] dispatch_tag   [SS],
    output rv32i_types::xlen_t           dispatch_pc    [SS],
    output rv32i_types::reg_idx_t        dispatch_rd    [SS],
    output rv32i_types::reg_idx_t        dispatch_rs1   [SS],
    output rv32i_types::reg_idx_t        dispatch_rs2   [SS],
    output rv32i_types::xlen_t           dispatch_imm   [SS],
    output rv32i_types::op_class_t       dispatch_class [SS]
);

    import rv32i_types::*;

    queue_entry_t             in_group  [SS];
    queue_entry_t             out_group [SS];
    queue_entry_t             peek_data;
    logic                     q_empty;
    logic                     out_strobe;
    logic                     pop;
    logic [$clog2(DEPTH):0]   q_count;

    lane_if lane_bus [SS] ();

    for (genvar g = 0; g < SS; g++) begin : g_pack
        assign in_group[g] = '{valid: fetch_valid[g], pc: fetch_pc[g], instr: fetch_instr[g]};
    end

    assign pop   = !stall && !q_empty; // Stall only holds back new groups.
    assign empty = (q_count == '0);

    assign peek_valid_bit = peek_data.valid;
    assign peek_pc        = peek_data.pc;
    assign peek_instr     = peek_data.instr;

    circular_queue #(
        .QUEUE_TYPE (queue_entry_t),
        .SS         (SS),
        .DEPTH      (DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .in_group   (in_group),
        .peek_en    (peek_en),
        .peek_index (peek_index),
        .empty      (q_empty),
        .full       (full),
        .count      (q_count),
        .out_group  (out_group),
        .out_strobe (out_strobe),
        .peek_data  (peek_data)
    );

    for (genvar g = 0; g < SS; g++) begin : g_lane
        decode_lane u_lane (
            .clk         (clk),
            .rst         (rst),
            .slot_strobe (out_strobe),
            .slot        (out_group[g]),
            .dec         (lane_bus[g])
        );
    end

    dispatch_merge #(
        .SS        (SS),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_merge (
        .clk            (clk),
        .rst            (rst),
        .lanes          (lane_bus),
        .dispatch_valid (dispatch_valid),
        .dispatch_tag   (dispatch_tag),
        .dispatch_pc    (dispatch_pc),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .dispatch_class (dispatch_class)
    );

endmodule : decode_stage_top

//--- tb/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

    import rv32i_types::*;

    localparam int SS        = 2;
    localparam int DEPTH     = 8;
    localparam int ROB_DEPTH = 16;
    localparam int AW        = $clog2(DEPTH);
    localparam int TW        = $clog2(ROB_DEPTH);
    localparam int MAX_LINES = 64;

    logic          clk = 1'b0;
    logic          rst;
    logic          push;
    logic          stall;
    logic          peek_en;
    logic          fetch_valid [SS];
    xlen_t         fetch_pc    [SS];
    instr_t        fetch_instr [SS];
    logic [AW-1:0] peek_index;
    logic          empty;
    logic          full;
    logic          peek_valid_bit;
    xlen_t         peek_pc;
    instr_t        peek_instr;
    logic          dispatch_valid [SS];
    logic [TW-1:0] dispatch_tag   [SS];
    xlen_t         dispatch_pc    [SS];
    reg_idx_t      dispatch_rd    [SS];
    reg_idx_t      dispatch_rs1   [SS];
    reg_idx_t      dispatch_rs2   [SS];
    xlen_t         dispatch_imm   [SS];
    op_class_t     dispatch_class [SS];

    // Slots and expected fields from the data file.
    logic      d_valid [MAX_LINES];
    xlen_t     d_pc    [MAX_LINES];
    instr_t    d_instr [MAX_LINES];
    op_class_t d_class [MAX_LINES];
    reg_idx_t  d_rd    [MAX_LINES];
    reg_idx_t  d_rs1   [MAX_LINES];
    reg_idx_t  d_rs2   [MAX_LINES];
    xlen_t     d_imm   [MAX_LINES];
    int        n_lines;
    int        next_line;

    // Last value written to each queue slot.
    logic   m_valid [DEPTH];
    xlen_t  m_pc    [DEPTH];
    instr_t m_instr [DEPTH];
    int     groups;

    int            exp_q [$]; // Data lines waiting for dispatch, in fetch order.
    logic [TW-1:0] exp_tag;
    logic [31:0]   seed;
    int            errors;
    int            checks;
    int            stall_run;
    int            cycles = 0;
    int            limit  = 1000;

    decode_stage_top #(
        .SS        (SS),
        .DEPTH     (DEPTH),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_decode_stage (
        .clk            (clk),
        .rst            (rst),
        .push           (push),
        .stall          (stall),
        .peek_en        (peek_en),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .peek_index     (peek_index),
        .empty          (empty),
        .full           (full),
        .peek_valid_bit (peek_valid_bit),
        .peek_pc        (peek_pc),
        .peek_instr     (peek_instr),
        .dispatch_valid (dispatch_valid),
        .dispatch_tag   (dispatch_tag),
        .dispatch_pc    (dispatch_pc),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .dispatch_class (dispatch_class)
    );

    always #5 clk = ~clk;

    // Number of edges in a row that saw stall high.
    always @(posedge clk) begin
        if (rst) begin
            stall_run <= 0;
        end else if (stall) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, %0d slots never dispatched", limit, exp_q.size());
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string lane_name(input string base, input int i);
        return $sformatf("%s[%0d]", base, i);
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_class(input string name, input op_class_t got, input op_class_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input logic [TW-1:0] got,
                             input logic [TW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task load_data();
        int          fd;
        int          code;
        string       line;
        logic [31:0] t_v;
        logic [31:0] t_pc;
        logic [31:0] t_ins;
        logic [31:0] t_cls;
        logic [31:0] t_rd;
        logic [31:0] t_rs1;
        logic [31:0] t_rs2;
        logic [31:0] t_imm;
        n_lines = 0;
        fd = $fopen("tb/testdata_decode.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/testdata_decode.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                   t_v, t_pc, t_ins, t_cls, t_rd, t_rs1, t_rs2, t_imm);
                    if (code == 8) begin
                        d_valid[n_lines] = t_v[0];
                        d_pc[n_lines]    = t_pc;
                        d_instr[n_lines] = t_ins;
                        d_class[n_lines] = op_class_t'(t_cls);
                        d_rd[n_lines]    = reg_idx_t'(t_rd);
                        d_rs1[n_lines]   = reg_idx_t'(t_rs1);
                        d_rs2[n_lines]   = reg_idx_t'(t_rs2);
                        d_imm[n_lines]   = t_imm;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Compare each valid lane with the oldest expected slot.
    task check_dispatch();
        int idx;
        for (int i = 0; i < SS; i++) begin
            if (dispatch_valid[i] && exp_q.size() == 0) begin
                errors++;
                $display("Lane %0d dispatched a slot that was never expected", i);
            end else if (dispatch_valid[i]) begin
                idx = exp_q.pop_front();
                check_word(lane_name("dispatch_pc", i), dispatch_pc[i], d_pc[idx]);
                check_reg(lane_name("dispatch_rd", i), dispatch_rd[i], d_rd[idx]);
                check_reg(lane_name("dispatch_rs1", i), dispatch_rs1[i], d_rs1[idx]);
                check_reg(lane_name("dispatch_rs2", i), dispatch_rs2[i], d_rs2[idx]);
                check_word(lane_name("dispatch_imm", i), dispatch_imm[i], d_imm[idx]);
                check_class(lane_name("dispatch_class", i), dispatch_class[i], d_class[idx]);
                check_tag(lane_name("dispatch_tag", i), dispatch_tag[i], exp_tag);
                exp_tag = exp_tag + TW'(1); // Wraps at ROB_DEPTH.
            end
        end
    endtask

    // Advance to the next falling edge and look at the outputs there.
    task step();
        @(negedge clk);
        if (stall_run >= 3) begin
            for (int i = 0; i < SS; i++) begin
                if (dispatch_valid[i]) begin
                    errors++;
                    $display("Lane %0d dispatched after stall was held three cycles", i);
                end
            end
        end
        check_dispatch();
    endtask

    task drive_group(input bit accept);
        int slot;
        for (int l = 0; l < SS; l++) begin
            fetch_valid[l] = d_valid[next_line + l];
            fetch_pc[l]    = d_pc[next_line + l];
            fetch_instr[l] = d_instr[next_line + l];
            if (accept) begin
                slot = (groups * SS + l) % DEPTH;
                m_valid[slot] = d_valid[next_line + l];
                m_pc[slot]    = d_pc[next_line + l];
                m_instr[slot] = d_instr[next_line + l];
                if (d_valid[next_line + l]) begin
                    exp_q.push_back(next_line + l);
                end
            end
        end
        push = 1'b1;
        if (accept) begin
            groups++;
        end
        next_line += SS;
    endtask

    task peek_check(input int k);
        peek_en    = 1'b1;
        peek_index = AW'(k);
        step();
        peek_en = 1'b0;
        check_flag("peek_valid_bit", peek_valid_bit, m_valid[k]);
        check_word("peek_pc", peek_pc, m_pc[k]);
        check_word("peek_instr", peek_instr, m_instr[k]);
    endtask

    task run_tests();
        int          n;
        logic [31:0] r;
        check_flag("empty", empty, 1'b1);
        check_flag("full", full, 1'b0);
        for (int i = 0; i < SS; i++) begin
            check_flag(lane_name("dispatch_valid", i), dispatch_valid[i], 1'b0);
        end

        // Fill behind a stalled consumer, then push once more into a full queue.
        stall = 1'b1;
        for (int g = 0; g < DEPTH / SS; g++) begin
            if (full) begin
                errors++;
                $display("Queue reported full after only %0d groups", g);
            end
            drive_group(1'b1);
            step();
        end
        check_flag("full", full, 1'b1);
        check_flag("empty", empty, 1'b0);
        drive_group(1'b0);
        step();
        push = 1'b0;
        check_flag("full", full, 1'b1);
        for (int k = 0; k < DEPTH; k++) begin
            peek_check(k);
        end
        peek_index = '0; // Point at another slot while peek_en is low.
        step();
        check_word("peek_pc", peek_pc, m_pc[DEPTH-1]); // Held with peek_en low.

        n = 0;
        while (next_line + SS <= n_lines) begin
            seed = lcg_next(seed);
            r    = seed;
            stall = (n >= 8 && n < 20) || (r[31:28] < 4'd4); // One long stall window.
            if (!full && r[27:20] < 8'd150) begin
                drive_group(1'b1);
            end else begin
                push = 1'b0;
            end
            step();
            n++;
        end

        push  = 1'b0;
        stall = 1'b0;
        while (exp_q.size() != 0 || !empty) begin
            step();
        end
        repeat (4) step();
        check_flag("empty", empty, 1'b1);
        for (int k = 0; k < DEPTH; k++) begin
            peek_check(k); // Pops leave the entries in place.
        end
    endtask

    initial begin
        rst        = 1'b1;
        push       = 1'b0;
        stall      = 1'b0;
        peek_en    = 1'b0;
        peek_index = '0;
        for (int l = 0; l < SS; l++) begin
            fetch_valid[l] = 1'b0;
            fetch_pc[l]    = '0;
            fetch_instr[l] = '0;
        end
        for (int k = 0; k < DEPTH; k++) begin
            m_valid[k] = 1'b0;
            m_pc[k]    = '0;
            m_instr[k] = '0;
        end
        errors    = 0;
        checks    = 0;
        groups    = 0;
        next_line = 0;
        exp_tag   = '0;
        seed      = 32'hbb83;
        load_data();
        limit = 20 * n_lines + 100;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (n_lines >= 10) begin
            run_tests();
        end else begin
            errors++;
            $display("Data file missing or holding fewer than ten slots");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_decode_stage

//--- tb/testdata_decode.txt
# valid pc instr class rd rs1 rs2 imm, all hex, one queue slot per line
# class: 0 alu, 1 load, 2 store, 3 branch, 4 jump, 5 illegal
1 00001000 00500093 0 01 00 05 00000005
1 00001004 fff08113 0 02 01 1f ffffffff
1 00001008 002081b3 0 03 01 02 00000000
1 0000100c 123452b7 0 05 08 03 12345000
1 00001010 fffff317 0 06 1f 1f fffff000
0 00001014 00812383 1 07 02 08 00000008
1 00001018 00812383 1 07 02 08 00000008
1 0000101c ffc18403 1 08 03 1c fffffffc
1 00001020 00512623 2 0c 02 05 0000000c
1 00001024 fe608c23 2 18 01 06 fffffff8
1 00001028 00512623 2 0c 02 05 0000000c
1 0000102c fe608c23 2 18 01 06 fffffff8
1 00001030 00208863 3 10 01 02 00000010
1 00001034 fe019ee3 3 1d 03 00 fffffffc
1 00001038 001000ef 4 01 00 01 00000800
1 0000103c ff9ff06f 4 00 1f 19 fffffff8
1 00001040 004280e7 4 01 05 04 00000004
1 00001044 ffffffff 5 1f 1f 1f 00000000
0 00001048 00000000 5 00 00 00 00000000
1 0000104c 00000000 5 00 00 00 00000000
1 00001050 7ff5f513 0 0a 0b 1f 000007ff
1 00001054 40e68633 0 0c 0d 0e 00000000
1 00001058 02524063 3 00 04 05 00000020
0 0000105c 40e68633 0 0c 0d 0e 00000000
0 00001060 00500093 0 01 00 05 00000005
1 00001064 80086793 0 0f 10 00 fffff800
1 00001068 7fff2fa3 2 1f 1e 1f 000007ff
1 0000106c 80000fb7 0 1f 00 00 80000000
1 00001070 100ada03 1 14 15 00 00000100
1 00001074 1234560b 5 0c 08 03 00000000
1 00001078 00008067 4 00 01 00 00000000
1 0000107c 80737063 3 00 06 07 fffff000
1 00001080 0000007f 5 00 00 00 00000000
0 00001084 001000ef 4 01 00 01 00000800
1 00001088 00500093 0 01 00 05 00000005
1 0000108c 002081b3 0 03 01 02 00000000
1 00001090 ff9ff06f 4 00 1f 19 fffffff8
1 00001094 00512623 2 0c 02 05 0000000c
1 00001098 ffc18403 1 08 03 1c fffffffc
1 0000109c fe019ee3 3 1d 03 00 fffffffc

//--- files.f
logic/rv32i_types.sv
logic/lane_if.sv
logic/circular_queue.sv
logic/decode_lane.sv
logic/dispatch_merge.sv
logic/decode_stage_top.sv
tb/tb_decode_stage.sv

//--- Makefile
# Verilator build and run for the decode stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
